// File: sim.f
+incdir+hw
hw/sink_pkg.sv
hw/sink_addr_gen.sv
hw/sink_addr_fifo.sv
hw/sink_realign.sv
hw/sink_fsm.sv
hw/sink_streamer.sv
verif/tb_sink_streamer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the store streamer testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_sink_streamer \
  -o tb_sink_streamer

# the run may stop on a fatal error, the log decides
./obj_dir/tb_sink_streamer > sim.log 2>&1 || true
cat sim.log

if grep -q "Test OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// File: verif/tb_sink_streamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store streamer testbench
// clock, reset, stream and grant drivers
// store logger, reference model, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module tb_sink_streamer;

  // words over all jobs with the clear job counted in full
  localparam int TOTAL_WORDS    = 8 + 3 * 6 + 16 + 0 + 20 + 5;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 200;
  localparam int MAX_LEN        = 64;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   clear_i;
  logic                   start_i;
  sink_pkg::sink_ctrl_t   ctrl_i;
  sink_pkg::sink_flags_t  flags_o;
  sink_pkg::stream_beat_t beat_i;
  logic                   beat_valid_i;
  logic                   beat_ready_o;
  logic                   mem_req_o;
  sink_pkg::mem_req_t     mem_o;
  logic                   mem_gnt_i;

  integer seed;
  int     gnt_pct;      // grant probability in percent
  bit     gnt_block;    // forces grant low
  bit     abort;        // stops the beat driver
  int     cycle_cnt = 0;
  int     err_cnt   = 0;
  int     done_cnt  = 0;
  int     store_total = 0;

  // current job as seen by the compare process
  logic [31:0]            cur_base;
  logic [15:0]            cur_stride;
  int                     cur_len;
  int                     exp_idx;
  sink_pkg::stream_beat_t job_beats [MAX_LEN];
  sink_pkg::mem_req_t     store_q [$];   // stores seen on the port

  sink_streamer UUT (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .start_i      ( start_i      ),
    .ctrl_i       ( ctrl_i       ),
    .flags_o      ( flags_o      ),
    .beat_i       ( beat_i       ),
    .beat_valid_i ( beat_valid_i ),
    .beat_ready_o ( beat_ready_o ),
    .mem_req_o    ( mem_req_o    ),
    .mem_o        ( mem_o        ),
    .mem_gnt_i    ( mem_gnt_i    )
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  // expected store for word idx built byte by byte
  function automatic sink_pkg::mem_req_t exp_store(input logic [31:0] base,
                                                   input logic [15:0] stride,
                                                   input int idx,
                                                   input sink_pkg::stream_beat_t beat);
    sink_pkg::mem_req_t r;
    logic [31:0]        byte_addr;
    int                 lane;
    int                 k;
    r         = '0;
    byte_addr = base + 32'(idx) * 32'(stride);
    r.addr    = {byte_addr[31:2], 2'b00};
    for (k = 0; k < 4; k++) begin
      lane = int'(byte_addr[1:0]) + k;  // up to lane 6
      r.data[lane*8 +: 8] = beat.data[k*8 +: 8];
      r.be[lane]          = beat.strb[k];
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // run length guard
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // memory model logging every granted store
  always @(posedge clk_i) begin
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      store_q.push_back(mem_o);
      store_total++;
    end
    if (rst_ni && flags_o.done) done_cnt++;
  end

  // random grant roughly gnt_pct percent on
  always @(negedge clk_i) begin
    if (gnt_block) mem_gnt_i = 1'b0;
    else           mem_gnt_i = ({$random(seed)} % 100) < gnt_pct;
  end

  // compares logged stores in order against the reference
  always @(negedge clk_i) begin : compare_stores
    sink_pkg::mem_req_t got;
    while (store_q.size() != 0) begin
      got = store_q.pop_front();
      check("store within job length", 128'(exp_idx < cur_len), 128'(1));
      check($sformatf("store %0d payload", exp_idx), 128'(got),
            128'(exp_store(cur_base, cur_stride, exp_idx, job_beats[exp_idx])));
      exp_idx++;
    end
  end

  // drives n beats in order with valid held until the transfer
  task automatic send_beats(input int n, input bit drops);
    int idx;
    bit sent;
    idx  = 0;
    sent = 0;
    while (idx < n && !abort) begin
      @(negedge clk_i);
      if (sent) begin
        beat_valid_i = 1'b0;
        sent         = 0;
      end
      if (!beat_valid_i && (!drops || ({$random(seed)} % 4) != 0)) begin
        beat_i       = job_beats[idx];
        beat_valid_i = 1'b1;
      end
      @(posedge clk_i);
      if (beat_valid_i && beat_ready_o) begin
        idx++;
        sent = 1;
      end
    end
    @(negedge clk_i);
    beat_valid_i = 1'b0;
  endtask

  // builds the beats and the job context then pulses start
  task automatic start_job(input logic [31:0] base, input logic [15:0] stride,
                           input logic [15:0] len, input bit rand_strb);
    int i;
    for (i = 0; i < int'(len); i++) begin
      job_beats[i].data = $random(seed);
      job_beats[i].strb = rand_strb ? 4'($random(seed)) : 4'hF;
    end
    @(negedge clk_i);
    check("ready before start", 128'(flags_o.ready), 128'(1));
    cur_base         = base;
    cur_stride       = stride;
    cur_len          = int'(len);
    exp_idx          = 0;
    ctrl_i.base_addr = base;
    ctrl_i.stride    = stride;
    ctrl_i.len       = len;
    start_i          = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    check("ready low after start", 128'(flags_o.ready), 128'(0));
    check("gen_done cleared by start", 128'(flags_o.gen_done), 128'(0));
  endtask

  task automatic wait_done();
    @(posedge clk_i);
    while (!flags_o.done) begin
      @(posedge clk_i);
    end
    check("ready with done pulse", 128'(flags_o.ready), 128'(1));
    check("gen_done with done pulse", 128'(flags_o.gen_done), 128'(1));
    // last grant was a cycle earlier and is already compared
    check("all stores before done", 128'(exp_idx), 128'(cur_len));
  endtask

  // one complete job with store and done pulse counts
  task automatic run_job(input logic [31:0] base, input logic [15:0] stride,
                         input logic [15:0] len, input bit rand_strb,
                         input bit drops, input bit busy_start);
    int done_before;
    int stores_before;
    done_before   = done_cnt;
    stores_before = store_total;
    start_job(base, stride, len, rand_strb);
    fork
      send_beats(int'(len), drops);
      wait_done();
      begin
        if (busy_start) begin
          repeat (3) @(negedge clk_i);
          check("ready low while busy", 128'(flags_o.ready), 128'(0));
          start_i = 1'b1;   // must be ignored
          @(negedge clk_i);
          start_i = 1'b0;
        end
      end
    join
    repeat (3) @(negedge clk_i);
    check("done pulses per job", 128'(done_cnt - done_before), 128'(1));
    check("stores per job", 128'(store_total - stores_before), 128'(len));
    check("stores compared", 128'(exp_idx), 128'(len));
    check("ready after job", 128'(flags_o.ready), 128'(1));
  endtask

  // aborts a long job part way through
  task automatic clear_job();
    int stores_at_clear;
    int i;
    start_job(32'h2000, 16'd4, 16'd20, 1'b0);
    abort = 0;
    fork
      send_beats(20, 1'b1);
      begin
        while (exp_idx < 5) begin
          @(posedge clk_i);
        end
        gnt_block = 1;      // nothing granted in the clear cycle
        @(negedge clk_i);
        clear_i = 1'b1;
        abort   = 1;
        @(negedge clk_i);
        clear_i = 1'b0;
      end
    join
    stores_at_clear = store_total;
    // beat offered and grants open so a live job would still store
    gnt_block    = 0;
    beat_i       = job_beats[5];
    beat_valid_i = 1'b1;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check("no request after clear", 128'(mem_req_o), 128'(0));
      check("ready after clear", 128'(flags_o.ready), 128'(1));
    end
    beat_valid_i = 1'b0;
    check("no store after clear", 128'(store_total), 128'(stores_at_clear));
    abort = 0;
  endtask

  initial begin : main_seq
    seed         = 32'h727;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    start_i      = 1'b0;
    ctrl_i       = '0;
    beat_i       = '0;
    beat_valid_i = 1'b0;
    mem_gnt_i    = 1'b0;
    gnt_pct      = 100;
    gnt_block    = 0;
    abort        = 0;
    cur_base     = '0;
    cur_stride   = '0;
    cur_len      = 0;
    exp_idx      = 0;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // idle state straight out of reset
    check("ready after reset", 128'(flags_o.ready), 128'(1));
    check("done after reset", 128'(flags_o.done), 128'(0));
    check("gen_done after reset", 128'(flags_o.gen_done), 128'(0));
    check("req after reset", 128'(mem_req_o), 128'(0));
    check("beat ready after reset", 128'(beat_ready_o), 128'(0));

    run_job(32'h100, 16'd4, 16'd8, 1'b0, 1'b0, 1'b0);  // aligned at full rate

    gnt_pct = 70;
    run_job(32'h201, 16'd5, 16'd6, 1'b0, 1'b1, 1'b0);  // offset 1
    run_job(32'h302, 16'd5, 16'd6, 1'b0, 1'b1, 1'b0);  // offset 2
    run_job(32'h403, 16'd5, 16'd6, 1'b0, 1'b1, 1'b0);  // offset 3

    // back-pressure on both sides plus a start while busy
    run_job(32'h1000, 16'd8, 16'd16, 1'b1, 1'b1, 1'b1);

    run_job(32'h500, 16'd4, 16'd0, 1'b0, 1'b0, 1'b0);  // empty job

    clear_job();
    run_job(32'h3002, 16'd12, 16'd5, 1'b1, 1'b1, 1'b0);

    repeat (2) @(negedge clk_i);
    if (err_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "errors were found");
    end
  end

endmodule

// File: hw/sink_streamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store streamer top level
// strided stream stores to the memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module sink_streamer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,       // synchronous abort
  // control plane
  input  logic                   start_i,       // taken only when ready
  input  sink_pkg::sink_ctrl_t   ctrl_i,
  output sink_pkg::sink_flags_t  flags_o,
  // incoming stream
  input  sink_pkg::stream_beat_t beat_i,
  input  logic                   beat_valid_i,
  output logic                   beat_ready_o,
  // memory store port
  output logic                   mem_req_o,
  output sink_pkg::mem_req_t     mem_o,
  input  logic                   mem_gnt_i
);

  logic                    busy;
  logic                    gen_en, gen_clr, gen_done;
  logic                    push;
  logic [`SINK_ADDR_W-1:0] push_addr;
  logic [`SINK_ADDR_W-1:0] head_addr;   // address for the current beat
  logic                    fifo_empty, fifo_full;
  logic                    store_fire;  // one word granted

  sink_fsm i_fsm (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clr_i        ( clear_i       ),
    .start_i      ( start_i       ),
    .len_i        ( ctrl_i.len    ),
    .gen_done_i   ( gen_done      ),
    .store_fire_i ( store_fire    ),
    .busy_o       ( busy          ),
    .gen_en_o     ( gen_en        ),
    .gen_clr_o    ( gen_clr       ),
    .ready_o      ( flags_o.ready ),
    .done_o       ( flags_o.done  )
  );

  sink_addr_gen i_addr_gen (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clr_i      ( gen_clr   ),
    .en_i       ( gen_en    ),
    .ctrl_i     ( ctrl_i    ),
    .full_i     ( fifo_full ),
    .push_o     ( push      ),
    .addr_o     ( push_addr ),
    .gen_done_o ( gen_done  )
  );

  sink_addr_fifo i_addr_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clr_i   ( clear_i    ),
    .push_i  ( push       ),
    .data_i  ( push_addr  ),
    .pop_i   ( store_fire ),  // address leaves with its beat
    .data_o  ( head_addr  ),
    .empty_o ( fifo_empty ),
    .full_o  ( fifo_full  )
  );

  sink_realign i_realign (
    .addr_i ( head_addr ),
    .beat_i ( beat_i    ),
    .req_o  ( mem_o     )
  );

  // a store needs an address and a beat at once
  assign mem_req_o    = busy & beat_valid_i & ~fifo_empty;
  assign store_fire   = mem_req_o & mem_gnt_i;
  assign beat_ready_o = store_fire;  // beat consumed only on grant

  assign flags_o.gen_done = gen_done;

  // payload must hold while the memory stalls
  a_payload_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i && !clear_i |=> mem_req_o && $stable(mem_o)
  ) else $error("store payload changed before grant");

endmodule

// File: hw/sink_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// streamer controller FSM
// granted-write counter, done pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module sink_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,         // abort to idle
  input  logic                   start_i,
  input  logic [`SINK_LEN_W-1:0] len_i,
  input  logic                   gen_done_i,
  input  logic                   store_fire_i,  // req and gnt both high
  output logic                   busy_o,
  output logic                   gen_en_o,
  output logic                   gen_clr_o,
  output logic                   ready_o,
  output logic                   done_o
);

  localparam int unsigned LEN_W = `SINK_LEN_W;

  sink_pkg::sink_state_e state_q, state_d;
  logic [LEN_W-1:0]      cnt_q;     // granted stores
  logic [LEN_W-1:0]      cnt_d;
  logic                  last;      // counter reaches len this cycle
  logic                  finish;
  logic                  done_q;

  assign cnt_d = cnt_q + LEN_W'(store_fire_i);
  assign last  = (cnt_d == len_i);

  always_comb begin
    state_d   = state_q;
    finish    = 1'b0;
    gen_clr_o = clr_i;
    case (state_q)
      sink_pkg::ST_IDLE: begin
        if (start_i) begin
          state_d   = sink_pkg::ST_WORKING;
          gen_clr_o = 1'b1;  // generator picks up the base
        end
      end
      sink_pkg::ST_WORKING: begin
        if (gen_done_i) begin
          // last grant can land with gen_done, skip finish then
          finish  = last;
          state_d = last ? sink_pkg::ST_IDLE : sink_pkg::ST_FINISH;
        end
      end
      sink_pkg::ST_FINISH: begin
        if (last) begin
          finish  = 1'b1;
          state_d = sink_pkg::ST_IDLE;
        end
      end
      default: state_d = sink_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= sink_pkg::ST_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (clr_i) begin
      state_q <= sink_pkg::ST_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;              // registered pulse
      cnt_q   <= finish ? '0 : cnt_d; // ready for next job
    end
  end

  assign busy_o   = (state_q != sink_pkg::ST_IDLE);
  assign ready_o  = (state_q == sink_pkg::ST_IDLE);
  assign gen_en_o = (state_q == sink_pkg::ST_WORKING);
  assign done_o   = done_q;

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {sink_pkg::ST_IDLE, sink_pkg::ST_WORKING, sink_pkg::ST_FINISH}
  ) else $error("controller state outside its encoding");

endmodule

// File: hw/sink_realign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beat realigner
// places a stream beat in the memory word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module sink_realign (
  input  logic [`SINK_ADDR_W-1:0] addr_i,  // byte address of this beat
  input  sink_pkg::stream_beat_t  beat_i,
  output sink_pkg::mem_req_t      req_o
);

  localparam int unsigned AW        = `SINK_ADDR_W;
  localparam int unsigned STREAM_DW = `SINK_STREAM_DW;
  localparam int unsigned MEM_DW    = `SINK_MEM_DW;
  localparam int unsigned STREAM_BW = STREAM_DW / 8;
  localparam int unsigned MEM_BW    = MEM_DW / 8;

  logic [1:0]        offset;     // byte lane of the first byte
  logic [MEM_DW-1:0] data_wide;  // beat in the low lanes
  logic [MEM_BW-1:0] be_wide;

  assign offset = addr_i[1:0];

  // zero-extend so the shifted-out lanes stay disabled
  assign data_wide = {{(MEM_DW - STREAM_DW){1'b0}}, beat_i.data};
  assign be_wide   = {{(MEM_BW - STREAM_BW){1'b0}}, beat_i.strb};

  always_comb begin
    req_o.addr = {addr_i[AW-1:2], 2'b00};      // word address
    req_o.data = data_wide << {offset, 3'b000}; // 8 bits per lane
    req_o.be   = be_wide << offset;
  end

endmodule

// File: hw/sink_addr_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular address FIFO
// full and empty flags, no bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module sink_addr_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clr_i,   // drop all entries
  input  logic                    push_i,
  input  logic [`SINK_ADDR_W-1:0] data_i,
  input  logic                    pop_i,
  output logic [`SINK_ADDR_W-1:0] data_o,  // head entry
  output logic                    empty_o,
  output logic                    full_o
);

  localparam int unsigned DEPTH = `SINK_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`SINK_ADDR_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]        cnt_q;     // occupancy

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];  // head read straight from storage

  // pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      // simultaneous push and pop leave the count alone
      cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  ) else $error("push into full address FIFO");

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  ) else $error("pop from empty address FIFO");

endmodule

// File: hw/sink_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strided address generator
// one push per free FIFO slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sink_cfg.svh"

module sink_addr_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clr_i,       // load base, restart count
  input  logic                    en_i,
  input  sink_pkg::sink_ctrl_t    ctrl_i,
  input  logic                    full_i,      // address FIFO full
  output logic                    push_o,
  output logic [`SINK_ADDR_W-1:0] addr_o,
  output logic                    gen_done_o
);

  localparam int unsigned AW    = `SINK_ADDR_W;
  localparam int unsigned LEN_W = `SINK_LEN_W;

  logic [AW-1:0]    addr_q;    // next address to issue
  logic [LEN_W-1:0] cnt_q;     // addresses issued so far
  logic [LEN_W-1:0] cnt_d;
  logic             done_q;

  // stop after len addresses and stall on full
  assign push_o = en_i & ~full_i & (cnt_q != ctrl_i.len);
  assign cnt_d  = cnt_q + LEN_W'(push_o);

  assign addr_o     = addr_q;
  assign gen_done_o = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (clr_i) begin
      addr_q <= ctrl_i.base_addr;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (en_i) begin
      cnt_q <= cnt_d;
      if (push_o) begin
        addr_q <= addr_q + AW'(ctrl_i.stride);  // stride is zero-extended
      end
      // covers the last push and a zero-length job alike
      if (cnt_d == ctrl_i.len) begin
        done_q <= 1'b1;  // sticky until next clear
      end
    end
  end

  // the FIFO never sees a push it cannot take, nor one past the job end
  a_push_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_o |-> !full_i && !gen_done_o
  ) else $error("address pushed while FIFO full or after gen_done");

  // each issued address sits at base plus count times stride
  a_addr_walk: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_o |-> addr_o == ctrl_i.base_addr + AW'(cnt_q) * AW'(ctrl_i.stride)
  ) else $error("issued address off the strided walk");

endmodule

// File: hw/sink_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store streamer types
// controller states, job config, flags
// stream beat and memory store payload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "sink_cfg.svh"

package sink_pkg;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,  // waiting for a start strobe
    ST_WORKING = 2'd1,  // generator still issuing addresses
    ST_FINISH  = 2'd2   // all addresses issued, draining stores
  } sink_state_e;

  // job configuration, held stable by the host while busy
  typedef struct packed {
    logic [`SINK_ADDR_W-1:0] base_addr;  // first byte address
    logic [`SINK_LEN_W-1:0]  stride;     // bytes between words
    logic [`SINK_LEN_W-1:0]  len;        // number of words
  } sink_ctrl_t;

  // status towards the host
  typedef struct packed {
    logic ready;     // idle, start accepted
    logic done;      // one-cycle pulse at end of job
    logic gen_done;  // sticky, every address issued
  } sink_flags_t;

  // one beat of the incoming data stream
  typedef struct packed {
    logic [`SINK_STREAM_DW-1:0]   data;
    logic [`SINK_STREAM_DW/8-1:0] strb;
  } stream_beat_t;

  // store towards the memory port
  typedef struct packed {
    logic [`SINK_ADDR_W-1:0]   addr;  // word aligned
    logic [`SINK_MEM_DW-1:0]   data;
    logic [`SINK_MEM_DW/8-1:0] be;
  } mem_req_t;

endpackage

// File: hw/sink_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store streamer config macros
// widths and address FIFO depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SINK_CFG_SVH
`define SINK_CFG_SVH

// byte address width
`define SINK_ADDR_W 32

// incoming stream beat width
`define SINK_STREAM_DW 32
// memory port is one word wider so a misaligned beat always fits
`define SINK_MEM_DW (`SINK_STREAM_DW + 32)

`define SINK_LEN_W 16      // job length and granted-write counter
`define SINK_FIFO_DEPTH 2  // also fine at 4 or 8

`endif
